// ==== rtl/percVar_cfg.svh ====
`ifndef PERCVAR_CFG_SVH
`define PERCVAR_CFG_SVH

// LAR segment bounds on |rc| >> 4
`define SEG1 16'sd1299
`define SEG2 16'sd1815
`define SEG3 16'sd1944

// Segment slopes and offsets
`define A1 16'sd4567
`define A2 16'sd11776
`define A3 16'sd27443
`define LB1 32'sd3271557
`define LB2 32'sd16357786
`define LB3 32'sd46808433

// Smoothing hysteresis
`define THRESH_L1 (-16'sd3562)
`define THRESH_L2 (-16'sd3116)
`define THRESH_H1 16'sd1336
`define THRESH_H2 16'sd890

`define GAMMA1_0 16'sd32113
`define GAMMA1_1 16'sd30802
`define GAMMA2_HI 16'sd22938
`define GAMMA2_LO 16'sd13107
`define GAMMA2_1 16'sd19661
`define ALPHA 16'sd19302
`define BETA 16'sd1024

`define LPC_ORDER 10
`define NUM_SUBFR 2

`endif

// ==== rtl/percPkg.sv ====
`include "percVar_cfg.svh"

package percPkg;

	// One Q15/Q13 sample
	typedef logic signed [15:0] wordT;

	// LSF vector of one subframe
	typedef wordT [`LPC_ORDER-1:0] lsfVecT;

	// [0],[1] subframe 0 (averaged), [2],[3] subframe 1 (new)
	typedef wordT [3:0] larQuadT;

	typedef struct packed
	{
		wordT rc0;
		wordT rc1;
		lsfVecT lsfInt;   // Interpolated LSFs
		lsfVecT lsfNew;
	} frameInT;

	typedef struct packed
	{
		wordT [`NUM_SUBFR-1:0] gamma1;
		wordT [`NUM_SUBFR-1:0] gamma2;
	} weightT;

endpackage

// ==== rtl/rcToLar.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module rcToLar
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic signed [15:0] rc,
	output logic signed [15:0] lar
);

	logic signed [15:0] mag;
	logic signed [15:0] cur;
	logic signed [15:0] half;
	logic signed [15:0] slope;
	logic signed [31:0] offset;
	logic signed [31:0] lTemp;
	logic signed [15:0] larMag;   // LAR before the sign goes back on

	always_comb
	begin
		mag = (rc == 16'sh8000) ? 16'sh7fff : (rc[15] ? -rc : rc);   // abs_s
		cur = mag >>> 4;
		half = cur >>> 1;
		slope = `A3;
		offset = `LB3;
		if (cur <= `SEG2)
		begin
			slope = `A1;
			offset = `LB1;
		end
		else if (cur <= `SEG3)
		begin
			slope = `A2;
			offset = `LB2;
		end
		lTemp = ((32'(half) * 32'(slope)) <<< 1) - offset;   // L_mult then L_sub
		if (cur <= `SEG1)
			larMag = cur;
		else if (cur <= `SEG2)
			larMag = 16'(lTemp >>> 11);
		else if (cur <= `SEG3)
			larMag = 16'(lTemp >>> 1);
		else
			larMag = 16'(lTemp >>> 11);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			lar <= '0;
		else if (load)
			lar <= rc[15] ? ((larMag == 16'sh8000) ? 16'sh7fff : -larMag) : larMag;
	end

	// Negative rc gives a non-positive LAR one cycle later
	assert property (@(posedge clk) disable iff (reset)
		(load && rc[15] && !larMag[15]) |=> (lar <= 16'sd0));

endmodule

// ==== rtl/larInterp.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module larInterp
	import percPkg::*;
(
	input logic clk,
	input logic reset,
	input logic update,
	input wordT larNew0,
	input wordT larNew1,
	output larQuadT lars
);

	wordT old0;   // Previous frame
	wordT old1;

	// add() then shr(,1)
	function automatic wordT avgSat(wordT a, wordT b);
		logic signed [16:0] s;
		wordT t;
		s = 17'(a) + 17'(b);
		if (s > 17'sd32767)
			t = 16'sh7fff;
		else if (s < -17'sd32768)
			t = 16'sh8000;
		else
			t = 16'(s);
		return t >>> 1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			old0 <= '0;
			old1 <= '0;
		end
		else if (update)
		begin
			old0 <= larNew0;
			old1 <= larNew1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (update)
		begin
			lars[0] <= avgSat(larNew0, old0);
			lars[1] <= avgSat(larNew1, old1);
			lars[2] <= larNew0;
			lars[3] <= larNew1;
		end
	end

endmodule

// ==== rtl/smoothDecide.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module smoothDecide
(
	input logic clk,
	input logic reset,
	input logic frameStart,
	input logic step,
	input logic signed [15:0] critLar0,
	input logic signed [15:0] critLar1,
	output logic smooth
);

	logic leave;   // Smooth to sharp
	logic enter;   // Sharp back to smooth

	always_comb
	begin
		leave = (critLar0 < `THRESH_L1) && (critLar1 > `THRESH_H1);
		enter = (critLar0 > `THRESH_L2) || (critLar1 < `THRESH_H2);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			smooth <= 1'b1;
		else if (frameStart)
			smooth <= 1'b1;   // Every frame starts smooth
		else if (step)
		begin
			if (smooth && leave)
				smooth <= 1'b0;
			else if (!smooth && enter)
				smooth <= 1'b1;
		end
	end

endmodule

// ==== rtl/lsfMinDist.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module lsfMinDist
	import percPkg::*;
(
	input logic clk,
	input logic reset,
	input logic scanStart,
	input lsfVecT lsf,
	output wordT dMin,
	output logic scanDone
);

	localparam logic [3:0] LAST_IDX = 4'(`LPC_ORDER - 2);

	lsfVecT lsfDbl;   // shl(lsf, 1)
	logic running;
	logic [3:0] idx;
	wordT gap;

	function automatic wordT sat16(logic signed [16:0] v);
		if (v > 17'sd32767)
			return 16'sh7fff;
		else if (v < -17'sd32768)
			return 16'sh8000;
		return 16'(v);
	endfunction

	always_comb
		gap = sat16(17'(lsfDbl[idx + 4'd1]) - 17'(lsfDbl[idx]));

	////////////////////
	// Scan control

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			idx <= '0;
			scanDone <= 1'b0;
		end
		else
		begin
			scanDone <= running && (idx == LAST_IDX);
			if (scanStart)
			begin
				running <= 1'b1;
				idx <= '0;
			end
			else if (running)
			begin
				if (idx == LAST_IDX)
					running <= 1'b0;
				else
					idx <= idx + 4'd1;
			end
		end
	end

	////////////////////
	// Data path

	always_ff @(posedge clk)
	begin
		if (scanStart)
		begin
			for (int i = 0; i < `LPC_ORDER; i++)
				lsfDbl[i] <= sat16({lsf[i], 1'b0});
		end
		if (running && ((idx == 4'd0) || (gap < dMin)))
			dMin <= gap;   // First spacing seeds the minimum
	end

	// Sequencer waits for scanDone before the next scan
	assert property (@(posedge clk) disable iff (reset) scanStart |-> !running);

endmodule

// ==== rtl/gammaCalc.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module gammaCalc
	import percPkg::*;
(
	input wordT dMin,
	input logic smooth,
	output wordT gamma1,
	output wordT gamma2
);

	logic signed [31:0] prod;
	logic signed [16:0] diff;
	wordT scaled;
	wordT shifted;
	wordT clamped;

	always_comb
	begin
		prod = 32'(`ALPHA) * 32'(dMin);
		scaled = 16'(prod >>> 15);   // mult(ALPHA, dMin)
		diff = 17'(`BETA) - 17'(scaled);
		// sub() result then shl(,5), both saturating
		if (diff > 17'sd1023)
			shifted = 16'sh7fff;
		else if (diff < -17'sd1024)
			shifted = 16'sh8000;
		else
			shifted = 16'(diff <<< 5);
		if (shifted > `GAMMA2_HI)
			clamped = `GAMMA2_HI;
		else if (shifted < `GAMMA2_LO)
			clamped = `GAMMA2_LO;
		else
			clamped = shifted;
		gamma1 = smooth ? `GAMMA1_1 : `GAMMA1_0;
		gamma2 = smooth ? `GAMMA2_1 : clamped;
	end

endmodule

// ==== rtl/percVar.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module percVar
	import percPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input frameInT frameIn,
	output logic busy,
	output logic done,
	output weightT weights
);

	localparam logic LAST_SUB = 1'(`NUM_SUBFR - 1);

	typedef enum logic [2:0] {IDLE, INTERP, DECIDE, STORE, SCAN} stateT;

	stateT state;
	logic sub;   // Current subframe
	logic accept, step, scanStart, scanDone, smooth, slotWrite, finish;
	wordT lar0, lar1, critLar0, critLar1, dMin, g1, g2, hold1, hold2;
	larQuadT lars;
	lsfVecT lsfInt, lsfNew;

	////////////////////
	// Sequencer decode

	always_comb
	begin
		accept = start && (state == IDLE);   // LARs convert on this edge
		slotWrite = ((state == STORE) && smooth) || ((state == SCAN) && scanDone);
		finish = slotWrite && (sub == LAST_SUB);
		step = (state == DECIDE) || (slotWrite && (sub != LAST_SUB));   // Next subframe
		scanStart = (state == STORE) && !smooth;
		critLar0 = (state == DECIDE) ? lars[0] : lars[2];
		critLar1 = (state == DECIDE) ? lars[1] : lars[3];
	end

	assign busy = (state != IDLE);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			sub <= 1'b0;
			done <= 1'b0;
			weights <= '0;
		end
		else
		begin
			done <= finish;
			case (state)
				IDLE:
				begin
					if (start)
					begin
						state <= INTERP;
						sub <= 1'b0;
					end
				end
				INTERP: state <= DECIDE;
				DECIDE: state <= STORE;
				STORE:
				begin
					if (!smooth)
						state <= SCAN;
					else if (finish)
						state <= IDLE;
					else
						sub <= LAST_SUB;   // Stay here, flag for next subframe is pending
				end
				SCAN:
				begin
					if (scanDone)
					begin
						state <= (sub == LAST_SUB) ? IDLE : STORE;
						sub <= LAST_SUB;
					end
				end
				default: state <= IDLE;
			endcase
			if (finish)
			begin
				weights.gamma1 <= {g1, hold1};
				weights.gamma2 <= {g2, hold2};
			end
		end
	end

	// Subframe 0 result and LSF copy
	always_ff @(posedge clk)
	begin
		if (slotWrite && (sub != LAST_SUB))
		begin
			hold1 <= g1;
			hold2 <= g2;
		end
		if (accept)
		begin
			lsfInt <= frameIn.lsfInt;
			lsfNew <= frameIn.lsfNew;
		end
	end

	////////////////////
	// Datapath blocks

	rcToLar rcToLar0 (.clk, .reset, .load(accept), .rc(frameIn.rc0), .lar(lar0));
	rcToLar rcToLar1 (.clk, .reset, .load(accept), .rc(frameIn.rc1), .lar(lar1));

	larInterp larInterp0
	(
		.clk,
		.reset,
		.update(state == INTERP),
		.larNew0(lar0),
		.larNew1(lar1),
		.lars
	);

	smoothDecide smoothDecide0
	(
		.clk,
		.reset,
		.frameStart(accept),
		.step,
		.critLar0,
		.critLar1,
		.smooth
	);

	lsfMinDist lsfMinDist0
	(
		.clk,
		.reset,
		.scanStart,
		.lsf(sub ? lsfNew : lsfInt),
		.dMin,
		.scanDone
	);

	gammaCalc gammaCalc0 (.dMin, .smooth, .gamma1(g1), .gamma2(g2));

	assert property (@(posedge clk) disable iff (reset) done |=> !done);

endmodule

// ==== test/percVarChecker.sv ====
`timescale 1ns/10ps

module percVarChecker
	import percPkg::*;
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input logic expValid,
	input weightT expWeights,
	input weightT weights,
	output int errCount,
	output int protoCount
);

	weightT pendingQ[$];   // Expected results in frame order
	weightT want;
	int frameIdx;
	logic inFrame;   // A frame is in flight

	task automatic compareWord(string what, logic [15:0] exp, logic [15:0] got);
		if (exp !== got)
		begin
			$display("CHECK FAILED at %0t: frame %0d %s expected %h got %h",
				$time, frameIdx, what, exp, got);
			errCount++;
		end
	endtask

	always @(posedge clk)
	begin
		if (reset)
		begin
			pendingQ.delete();
			frameIdx = 0;
			errCount = 0;
			protoCount = 0;
			inFrame = 1'b0;
		end
		else
		begin
			// Busy from the cycle after an accepted start, low again on done
			if (busy !== (inFrame && !done))
			begin
				$display("CHECK FAILED at %0t: busy expected %b got %b",
					$time, inFrame && !done, busy);
				errCount++;
			end
			if (done)
				inFrame = 1'b0;
			if (start && !inFrame)
				inFrame = 1'b1;   // Start while busy is dropped
			if (expValid)
				pendingQ.push_back(expWeights);
			if (done)
			begin
				if (pendingQ.size() == 0)
				begin
					$display("Extra done pulse at %0t with no frame outstanding", $time);
					protoCount++;
				end
				else
				begin
					want = pendingQ.pop_front();
					compareWord("gamma1[0]", want.gamma1[0], weights.gamma1[0]);
					compareWord("gamma1[1]", want.gamma1[1], weights.gamma1[1]);
					compareWord("gamma2[0]", want.gamma2[0], weights.gamma2[0]);
					compareWord("gamma2[1]", want.gamma2[1], weights.gamma2[1]);
					frameIdx++;
				end
			end
		end
	end

endmodule

// ==== test/tbPercVar.sv ====
`timescale 1ns/10ps
`include "percVar_cfg.svh"

module tbPercVar
	import percPkg::*;
();

	logic clk = 1'b0;
	logic reset;
	logic start;
	frameInT frameIn;
	logic busy;
	logic done;
	weightT weights;
	logic expValid;
	weightT expWeights;
	int checkErrs;
	int protoErrs;
	int tbErrs;

	frameInT frames[$];
	weightT expected[$];
	logic dupStart[$];
	logic loaded = 1'b0;
	logic [31:0] lfsr;

	always #5 clk = ~clk;   // 10 ns period

	// Galois LFSR, one step per bit
	function automatic logic nextBit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'hA3000000;
		return b;
	endfunction

	////////////////////
	// Golden file

	function automatic int loadGolden();
		int fd;
		int n;
		string skip;
		logic [15:0] v [0:26];
		frameInT f;
		weightT w;
		fd = $fopen("test/percVar_golden.txt", "r");
		if (fd == 0)
			return 0;
		n = $fgets(skip, fd);   // Two header lines
		n = $fgets(skip, fd);
		while (!$feof(fd))
		begin
			n = 0;
			for (int i = 0; i < 27; i++)
				if ($fscanf(fd, " %h", v[i]) == 1)
					n++;
			if (n == 27)
			begin
				f.rc0 = v[1];
				f.rc1 = v[2];
				for (int i = 0; i < `LPC_ORDER; i++)
				begin
					f.lsfInt[i] = v[7 + i];
					f.lsfNew[i] = v[17 + i];
				end
				w.gamma1[0] = v[3];
				w.gamma1[1] = v[4];
				w.gamma2[0] = v[5];
				w.gamma2[1] = v[6];
				frames.push_back(f);
				expected.push_back(w);
				dupStart.push_back(v[0][0]);
			end
		end
		$fclose(fd);
		return 1;
	endfunction

	////////////////////
	// Stimulus

	initial
	begin
		logic [2:0] gap;
		logic seen;
		int ok;
		reset = 1'b1;
		start = 1'b0;
		frameIn = '0;
		expValid = 1'b0;
		expWeights = '0;
		tbErrs = 0;
		lfsr = 32'hc91b;
		ok = loadGolden();
		if (ok == 0 || frames.size() == 0)
		begin
			$display("Could not read any frame from test/percVar_golden.txt");
			$display("Done: errors found");
			$finish;
		end
		else
		begin
			loaded = 1'b1;
			repeat (5) @(posedge clk);
			@(negedge clk);
			reset = 1'b0;
			foreach (frames[k])
			begin
				gap = {nextBit(), nextBit(), nextBit()};
				repeat (gap) @(negedge clk);
				@(negedge clk);
				start = 1'b1;
				frameIn = frames[k];
				expValid = 1'b1;
				expWeights = expected[k];
				@(negedge clk);
				start = 1'b0;
				expValid = 1'b0;
				if (dupStart[k])
				begin
					@(negedge clk);
					start = 1'b1;   // DUT is busy, must be ignored
					@(negedge clk);
					start = 1'b0;
				end
				seen = 1'b0;
				for (int c = 0; c < 40 && !seen; c++)
				begin
					@(posedge clk);
					seen = done;
				end
				if (!seen)
				begin
					$display("Frame %0d got no done pulse within 40 cycles", k);
					tbErrs++;
				end
			end
			repeat (10) @(posedge clk);   // Catch a late extra done
			$display("Frames %0d, value errors %0d, protocol errors %0d",
				frames.size(), checkErrs, protoErrs + tbErrs);
			if (checkErrs + protoErrs + tbErrs == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

	// Watchdog
	initial
	begin
		wait (loaded);
		#((frames.size() + 2) * 400);
		$display("Timeout, the run did not finish in the time allowed for %0d frames",
			frames.size());
		$display("Done: errors found");
		$finish;
	end

	percVar dut0
	(
		.clk,
		.reset,
		.start,
		.frameIn,
		.busy,
		.done,
		.weights
	);

	percVarChecker checker0
	(
		.clk,
		.reset,
		.start,
		.busy,
		.done,
		.expValid,
		.expWeights,
		.weights,
		.errCount(checkErrs),
		.protoCount(protoErrs)
	);

endmodule

// ==== test/percVar_golden.txt ====
// dup rc0 rc1 gamma1[0] gamma1[1] gamma2[0] gamma2[1] lsfInt[0..9] lsfNew[0..9], all hex
// dup 1 sends a second start pulse while the DUT is busy
0 1000 F000 7852 7852 4CCD 4CCD 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8
1 8000 7FFF 7852 7D71 4CCD 599A 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8 01F4 05DC 09C4 0DAC 1194 157C 1964 1D4C 2134 2166
0 8000 7FFF 7D71 7D71 3333 4520 01F4 05DC 09C4 0DAC 1194 157C 1964 1D4C 2134 251C 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8
0 8000 1000 7D71 7852 53E0 4CCD 03E8 07D0 0BB8 0CE4 10CC 14B4 189C 1C84 206C 2454 01F4 05DC 09C4 0DAC 1194 157C 1964 1D4C 2134 251C
1 6000 8C00 7852 7852 4CCD 4CCD 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8
0 A000 7400 7852 7852 4CCD 4CCD 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8
0 8000 7FFF 7852 7D71 4CCD 3333 03E8 0578 0708 0898 0A28 0BB8 0D48 0ED8 1068 11F8 01F4 05DC 09C4 0DAC 1194 157C 1964 1D4C 2134 251C
1 8001 7FFF 7D71 7D71 599A 53E0 01F4 05DC 09C4 0DAC 1194 157C 1964 1D4C 2134 2166 03E8 07D0 0BB8 0CE4 10CC 14B4 189C 1C84 206C 2454

// ==== tb.f ====
+incdir+rtl
rtl/percPkg.sv
rtl/rcToLar.sv
rtl/larInterp.sv
rtl/smoothDecide.sv
rtl/lsfMinDist.sv
rtl/gammaCalc.sv
rtl/percVar.sv
test/percVarChecker.sv
test/tbPercVar.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbPercVar
FILELIST = tb.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench into $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "no errors" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
